/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP       = edge_data_control_tb
FILELIST  = compile.f
RUN_ARGS  = +verilator+error+limit+1000
PASS_MSG  = All tests passed!

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* compile.f */
hdl/edge_data_pkg.sv
hdl/sync_fifo.sv
hdl/edge_job_decode.sv
hdl/vertex_read_master.sv
hdl/edge_data_result.sv
hdl/edge_data_control.sv
sim/clock_gen.sv
sim/edge_data_control_asserts.sv
sim/edge_data_control_tb.sv

/* hdl/edge_data_control.sv */
// Edge job to vertex data fetch; one Wishbone read in flight, up to FIFO_DEPTH commands and results queued
module edge_data_control import edge_data_pkg::*; (
	input  logic              clock,
	input  logic              rstn,
	input  logic [ADDR_W-1:0] base_address,
	input  edge_job_t         edge_job,
	output logic              edge_ready,
	output wb_m2s_t           wb_out,
	input  wb_s2m_t           wb_in,
	output edge_data_t        edge_data,
	input  logic              data_pop,
	output buffer_status_t    data_status
);

	logic           cmd_pop;
	read_cmd_t      cmd_head;
	buffer_status_t cmd_status;
	edge_data_t     result_push;
	buffer_status_t result_status;

	// Decode
	edge_job_decode u_decode (
		.clock       (clock),
		.rstn        (rstn),
		.base_address(base_address),
		.edge_job    (edge_job),
		.edge_ready  (edge_ready),
		.cmd_pop     (cmd_pop),
		.cmd_head    (cmd_head),
		.cmd_status  (cmd_status)
	);

	// Execute
	vertex_read_master u_read_master (
		.clock        (clock),
		.rstn         (rstn),
		.cmd_head     (cmd_head),
		.cmd_status   (cmd_status),
		.cmd_pop      (cmd_pop),
		.wb_out       (wb_out),
		.wb_in        (wb_in),
		.result_status(result_status),
		.result_push  (result_push)
	);

	// Result
	edge_data_result u_result (
		.clock        (clock),
		.rstn         (rstn),
		.result_push  (result_push),
		.result_status(result_status),
		.data_pop     (data_pop),
		.edge_data    (edge_data),
		.data_status  (data_status)
	);

endmodule

/* hdl/edge_data_pkg.sv */
// Vertex data is one 32-bit word per vertex at base plus index times four; depths assume a power of two
package edge_data_pkg;

	//////////////////////////////
	// Widths and queue sizing
	//////////////////////////////

	localparam int VERTEX_W      = 16;
	localparam int WEIGHT_W      = 16;
	localparam int ADDR_W        = 32;
	localparam int DATA_W        = 32;
	localparam int SEL_W         = DATA_W / 8;
	// log2 of bytes per vertex word
	localparam int DATA_SHIFT    = 2;

	localparam int FIFO_DEPTH    = 8;
	// Free slots left when alfull rises
	localparam int ALFULL_MARGIN = 2;
	localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W    = $clog2(FIFO_DEPTH + 1);

	//////////////////////////////
	// Pipeline records
	//////////////////////////////

	// Edge job from the producer
	typedef struct packed {
		logic                valid;
		logic [VERTEX_W-1:0] src;
		logic [VERTEX_W-1:0] dest;
		logic [WEIGHT_W-1:0] weight;
	} edge_job_t;

	// Read command, edge fields ride along as the tag
	typedef struct packed {
		logic                valid;
		logic [ADDR_W-1:0]   addr;
		logic [VERTEX_W-1:0] src;
		logic [VERTEX_W-1:0] dest;
		logic [WEIGHT_W-1:0] weight;
	} read_cmd_t;

	// Completed edge plus vertex data
	typedef struct packed {
		logic                valid;
		logic [VERTEX_W-1:0] src;
		logic [VERTEX_W-1:0] dest;
		logic [WEIGHT_W-1:0] weight;
		logic [DATA_W-1:0]   data;
	} edge_data_t;

	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
		logic valid;
	} buffer_status_t;

	//////////////////////////////
	// Wishbone classic bundles
	//////////////////////////////

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [ADDR_W-1:0] adr;
		logic [SEL_W-1:0]  sel;
	} wb_m2s_t;

	typedef struct packed {
		logic              ack;
		logic [DATA_W-1:0] dat;
	} wb_s2m_t;

endpackage

/* hdl/edge_data_result.sv */
// Records leave in push order; a pop with nothing queued is ignored
module edge_data_result import edge_data_pkg::*; (
	input  logic           clock,
	input  logic           rstn,
	input  edge_data_t     result_push,
	output buffer_status_t result_status,
	input  logic           data_pop,
	output edge_data_t     edge_data,
	output buffer_status_t data_status
);

	edge_data_t fifo_head;
	logic       data_take;

	// Only a visible record can be taken
	assign data_take = data_pop && edge_data.valid;

	//////////////////////////////
	// Result queue
	//////////////////////////////

	sync_fifo #(
		.WIDTH($bits(edge_data_t))
	) result_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (result_push.valid),
		.data_in (result_push),
		.pop     (data_take),
		.data_out(fifo_head),
		.status  (result_status)
	);

	//////////////////////////////
	// Consumer view
	//////////////////////////////

	always_comb begin
		edge_data       = fifo_head;
		edge_data.valid = ~result_status.empty;
	end

	// Consumer sees the same occupancy the execute stage throttles on
	assign data_status = result_status;

endmodule

/* hdl/edge_job_decode.sv */
// base_address is sampled on the accept edge; edge_ready lags the queue by one cycle, covered by ALFULL_MARGIN
module edge_job_decode import edge_data_pkg::*; (
	input  logic              clock,
	input  logic              rstn,
	input  logic [ADDR_W-1:0] base_address,
	input  edge_job_t         edge_job,
	output logic              edge_ready,
	input  logic              cmd_pop,
	output read_cmd_t         cmd_head,
	output buffer_status_t    cmd_status
);

	logic      job_accept;
	logic      cmd_valid;
	read_cmd_t cmd_data;
	read_cmd_t fifo_head;

	assign job_accept = edge_job.valid && edge_ready;

	//////////////////////////////
	// Job intake
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_ready <= 1'b0;
			cmd_valid  <= 1'b0;
		end else begin
			edge_ready <= ~cmd_status.alfull;
			cmd_valid  <= job_accept;
		end
	end

	// Byte address of the destination's data word
	always_ff @(posedge clock) begin
		if (job_accept) begin
			cmd_data.valid  <= 1'b1;
			cmd_data.addr   <= base_address + (ADDR_W'(edge_job.dest) << DATA_SHIFT);
			cmd_data.src    <= edge_job.src;
			cmd_data.dest   <= edge_job.dest;
			cmd_data.weight <= edge_job.weight;
		end
	end

	//////////////////////////////
	// Command queue
	//////////////////////////////

	sync_fifo #(
		.WIDTH($bits(read_cmd_t))
	) cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_valid),
		.data_in (cmd_data),
		.pop     (cmd_pop),
		.data_out(fifo_head),
		.status  (cmd_status)
	);

	// Stale entries never look valid
	always_comb begin
		cmd_head       = fifo_head;
		cmd_head.valid = cmd_status.valid;
	end

endmodule

/* hdl/sync_fifo.sv */
// First-word-fall-through queue of FIFO_DEPTH entries; push when full and pop when empty are dropped
module sync_fifo import edge_data_pkg::*; #(
	parameter int WIDTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output buffer_status_t   status
);

	logic [WIDTH-1:0]      mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	assign do_push = push && !status.full;
	assign do_pop  = pop && !status.empty;

	// Pointers and occupancy
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + FIFO_PTR_W'(1);
			if (do_pop)
				rd_ptr <= rd_ptr + FIFO_PTR_W'(1);
			if (do_push && !do_pop)
				count <= count + FIFO_CNT_W'(1);
			else if (do_pop && !do_push)
				count <= count - FIFO_CNT_W'(1);
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// Head is always visible, valid only when not empty
	assign data_out = mem[rd_ptr];

	assign status.full   = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign status.alfull = (count >= FIFO_CNT_W'(FIFO_DEPTH - ALFULL_MARGIN));
	assign status.empty  = (count == '0);
	assign status.valid  = (count != '0);

endmodule

/* hdl/vertex_read_master.sv */
// Single outstanding Wishbone classic read; memory must always ack, err and rty are not supported
module vertex_read_master import edge_data_pkg::*; (
	input  logic           clock,
	input  logic           rstn,
	input  read_cmd_t      cmd_head,
	input  buffer_status_t cmd_status,
	output logic           cmd_pop,
	output wb_m2s_t        wb_out,
	input  wb_s2m_t        wb_in,
	input  buffer_status_t result_status,
	output edge_data_t     result_push
);

	typedef enum logic {
		IDLE,
		BUSY
	} state_t;

	state_t    state;
	read_cmd_t cmd_q;
	logic      start;
	logic      done;

	// Need a command and room for its record
	assign start   = (state == IDLE) && cmd_status.valid && !result_status.alfull;
	assign done    = (state == BUSY) && wb_in.ack;
	assign cmd_pop = start;

	//////////////////////////////
	// Idle/busy FSM
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (start)
						state <= BUSY;
				end
				BUSY: begin
					// cyc and stb fall right after the ack edge
					if (wb_in.ack)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Command held for the whole bus cycle
	always_ff @(posedge clock) begin
		if (start)
			cmd_q <= cmd_head;
	end

	//////////////////////////////
	// Bus and result drive
	//////////////////////////////

	always_comb begin
		wb_out.cyc = (state == BUSY);
		wb_out.stb = (state == BUSY);
		wb_out.we  = 1'b0;
		wb_out.adr = cmd_q.addr;
		wb_out.sel = '1;
	end

	// Pushed on the ack edge itself
	always_comb begin
		result_push.valid  = done;
		result_push.src    = cmd_q.src;
		result_push.dest   = cmd_q.dest;
		result_push.weight = cmd_q.weight;
		result_push.data   = wb_in.dat;
	end

endmodule

/* sim/clock_gen.sv */
// Free-running 10 ns clock; rstn is held low for the first 5 rising edges and released on the 5th
module clock_gen (
	output logic clock,
	output logic rstn
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Release lands on a rising edge like any other input
	initial begin
		rstn = 1'b0;
		repeat (5) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

/* sim/edge_data_control_asserts.sv */
// Bus and result-flag properties for the top level; fail_count is read back by the testbench at the end
module edge_data_control_asserts import edge_data_pkg::*; (
	input logic           clock,
	input logic           rstn,
	input wb_m2s_t        wb_out,
	input wb_s2m_t        wb_in,
	input edge_data_t     edge_data,
	input buffer_status_t data_status
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_count = 0;

	//////////////////////////////
	// Wishbone master side
	//////////////////////////////

	stb_needs_cyc: assert property (@(posedge clock) disable iff (!rstn)
		wb_out.stb |-> wb_out.cyc)
		else begin
			$error("wb_out.stb high without wb_out.cyc");
			fail_count++;
		end

	// Address held until the slave acks
	adr_held: assert property (@(posedge clock) disable iff (!rstn)
		(wb_out.stb && !wb_in.ack) |=> $stable(wb_out.adr))
		else begin
			$error("wb_out.adr changed before ack");
			fail_count++;
		end

	read_only: assert property (@(posedge clock) disable iff (!rstn)
		!wb_out.we)
		else begin
			$error("wb_out.we went high");
			fail_count++;
		end

	//////////////////////////////
	// Consumer side
	//////////////////////////////

	valid_tracks_empty: assert property (@(posedge clock) disable iff (!rstn)
		edge_data.valid == !data_status.empty)
		else begin
			$error("edge_data.valid disagrees with data_status.empty");
			fail_count++;
		end

endmodule

bind edge_data_control edge_data_control_asserts chk (
	.clock      (clock),
	.rstn       (rstn),
	.wb_out     (wb_out),
	.wb_in      (wb_in),
	.edge_data  (edge_data),
	.data_status(data_status)
);

/* sim/edge_data_control_tb.sv */
// Memory model covers 65536 words, so addresses wrap on bits 17:2; checker instance is dut.chk via bind
module edge_data_control_tb import edge_data_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	logic              clock;
	logic              rstn;
	logic [ADDR_W-1:0] base_address;
	edge_job_t         edge_job;
	logic              edge_ready;
	wb_m2s_t           wb_out;
	wb_s2m_t           wb_in = '0;
	edge_data_t        edge_data;
	logic              data_pop;
	buffer_status_t    data_status;

	integer            seed = 32'h0f8e2116;
	integer            ack_seed = 32'h0f8e2116;
	logic [DATA_W-1:0] mem [65536];
	logic [ADDR_W-1:0] bus_q [$];
	edge_data_t        rec_q [$];
	int                errors = 0;
	int                tests_run = 0;
	int                tests_failed = 0;
	int                jobs_sent = 0;
	int                recs_taken = 0;
	int                bus_checks = 0;
	int                age = 0;
	int                delay = 0;

	clock_gen clkgen (
		.clock(clock),
		.rstn (rstn)
	);

	edge_data_control dut (
		.clock       (clock),
		.rstn        (rstn),
		.base_address(base_address),
		.edge_job    (edge_job),
		.edge_ready  (edge_ready),
		.wb_out      (wb_out),
		.wb_in       (wb_in),
		.edge_data   (edge_data),
		.data_pop    (data_pop),
		.data_status (data_status)
	);

	function automatic logic [15:0] word_index(input logic [ADDR_W-1:0] addr);
		return 16'(addr >> DATA_SHIFT);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("** Error %s: got %h, expected %h", name, got, exp);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		errors++;
	endtask

	//////////////////////////////
	// Memory model and monitor
	//////////////////////////////

	// Ack after 0 to 3 extra wait cycles
	always @(posedge clock) begin
		if (!rstn) begin
			wb_in <= '0;
			age <= 0;
		end else begin
			wb_in.ack <= 1'b0;
			if (wb_out.stb && !wb_in.ack) begin
				if (age == 0)
					delay = $random(ack_seed) & 3;
				if (age == delay) begin
					wb_in.ack <= 1'b1;
					wb_in.dat <= mem[word_index(wb_out.adr)];
					age <= 0;
				end else begin
					age <= age + 1;
				end
			end
		end
	end

	always @(posedge clock) begin : monitor
		logic [ADDR_W-1:0] addr;
		edge_data_t        exp;
		if (rstn) begin
			if (edge_job.valid && edge_ready) begin
				addr = base_address + ADDR_W'(edge_job.dest) * 4;
				bus_q.push_back(addr);
				exp = {1'b1, edge_job.src, edge_job.dest, edge_job.weight,
					mem[word_index(addr)]};
				rec_q.push_back(exp);
			end
			if (wb_out.stb && wb_in.ack) begin
				bus_checks++;
				if (bus_q.size() == 0) begin
					report_problem("Bus read completed with no job waiting for it");
				end else begin
					addr = bus_q.pop_front();
					if (wb_out.adr !== addr)
						report_mismatch("wb_out.adr", wb_out.adr, addr);
					if (wb_out.sel !== 4'hf)
						report_mismatch("wb_out.sel", 32'(wb_out.sel), 32'hf);
				end
			end
			if (data_pop && edge_data.valid) begin
				if (rec_q.size() == 0) begin
					report_problem("Record popped with no job outstanding");
				end else begin
					exp = rec_q.pop_front();
					if (edge_data.src !== exp.src)
						report_mismatch("edge_data.src", 32'(edge_data.src), 32'(exp.src));
					if (edge_data.dest !== exp.dest)
						report_mismatch("edge_data.dest", 32'(edge_data.dest), 32'(exp.dest));
					if (edge_data.weight !== exp.weight)
						report_mismatch("edge_data.weight", 32'(edge_data.weight),
							32'(exp.weight));
					if (edge_data.data !== exp.data)
						report_mismatch("edge_data.data", edge_data.data, exp.data);
				end
			end
		end
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	// Counts use the values the DUT sampled on this edge
	task automatic advance_clock();
		@(posedge clock);
		if (edge_job.valid && edge_ready)
			jobs_sent++;
		if (data_pop && edge_data.valid)
			recs_taken++;
	endtask

	function automatic edge_job_t make_job(input bit rand_valid);
		edge_job_t job;
		job.valid  = rand_valid ? 1'($random(seed)) : 1'b1;
		job.src    = 16'($random(seed));
		job.dest   = 16'($random(seed));
		job.weight = 16'($random(seed));
		return job;
	endfunction

	// pop_mode 0 holds pop low, 1 pops always, 2 pops at random
	task automatic send_jobs(input int n, input bit rand_valid, input int pop_mode);
		int target;
		int guard;
		target = jobs_sent + n;
		guard = 0;
		while (jobs_sent < target && guard < 5000) begin
			edge_job <= make_job(rand_valid);
			data_pop <= (pop_mode == 2) ? 1'($random(seed)) : (pop_mode == 1);
			advance_clock();
			guard++;
		end
		edge_job <= '0;
		if (jobs_sent < target)
			report_problem("Timed out waiting for the DUT to accept jobs");
	endtask

	// Pop until every accepted job has come back, then watch for extras
	task automatic drain_records();
		int guard;
		guard = 0;
		while (recs_taken < jobs_sent && guard < 5000) begin
			data_pop <= 1'b1;
			advance_clock();
			guard++;
		end
		if (recs_taken < jobs_sent)
			report_problem("Timed out waiting for queued records");
		repeat (8) advance_clock();
		data_pop <= 1'b0;
		if (recs_taken != jobs_sent)
			report_mismatch("records popped", recs_taken, jobs_sent);
	endtask

	task automatic check_idle_outputs();
		if (wb_out.cyc !== 1'b0)
			report_mismatch("wb_out.cyc", 32'(wb_out.cyc), 32'h0);
		if (wb_out.stb !== 1'b0)
			report_mismatch("wb_out.stb", 32'(wb_out.stb), 32'h0);
		if (edge_data.valid !== 1'b0)
			report_mismatch("edge_data.valid", 32'(edge_data.valid), 32'h0);
		if (data_status.empty !== 1'b1)
			report_mismatch("data_status.empty", 32'(data_status.empty), 32'h1);
		if (data_status.valid !== 1'b0)
			report_mismatch("data_status.valid", 32'(data_status.valid), 32'h0);
	endtask

	task automatic close_test(input string name, input int start);
		@(negedge clock);
		tests_run++;
		if (errors == start) begin
			$display("PASS  %s", name);
		end else begin
			tests_failed++;
			$display("FAIL  %s (%0d errors)", name, errors - start);
		end
		advance_clock();
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin : main
		int start;
		int guard;
		int checks;
		for (int i = 0; i < 65536; i++)
			mem[i] = $random(seed) ^ i;
		edge_job = '0;
		data_pop = 1'b0;
		base_address = 32'($random(seed)) & 32'hffff_fffc;

		start = errors;
		advance_clock();
		advance_clock();
		guard = 0;
		while (!rstn && guard < 50) begin
			check_idle_outputs();
			advance_clock();
			guard++;
		end
		if (!rstn)
			report_problem("Timed out waiting for reset release");
		check_idle_outputs();
		if (edge_ready !== 1'b0)
			report_mismatch("edge_ready", 32'(edge_ready), 32'h0);
		close_test("reset state", start);

		start = errors;
		checks = bus_checks;
		send_jobs(20, 1'b0, 1);
		drain_records();
		if (bus_checks - checks != 20)
			report_mismatch("bus cycles", bus_checks - checks, 20);
		close_test("address rule", start);

		start = errors;
		send_jobs(200, 1'b0, 1);
		drain_records();
		close_test("ordering and content, 200 jobs", start);

		start = errors;
		guard = 0;
		// Offer jobs until execute stalls and the command queue backs up behind it
		while ((edge_ready || !data_status.alfull) && guard < 500) begin
			edge_job <= make_job(1'b0);
			data_pop <= 1'b0;
			advance_clock();
			guard++;
		end
		edge_job <= '0;
		if (edge_ready || !data_status.alfull)
			report_problem("Queues never filled with the consumer stalled");
		guard = 0;
		while (wb_out.stb && guard < 50) begin
			advance_clock();
			guard++;
		end
		// Result queue is almost full, so no new bus cycle may open
		repeat (20) begin
			advance_clock();
			if (wb_out.stb)
				report_problem("Bus cycle started while the result queue was almost full");
			if (edge_ready !== 1'b0)
				report_mismatch("edge_ready", 32'(edge_ready), 32'h0);
			if (data_status.alfull !== 1'b1)
				report_mismatch("data_status.alfull", 32'(data_status.alfull), 32'h1);
			if (data_status.full !== 1'b0)
				report_mismatch("data_status.full", 32'(data_status.full), 32'h0);
		end
		drain_records();
		close_test("back-pressure", start);

		start = errors;
		repeat (3) begin
			base_address <= 32'($random(seed)) & 32'hffff_fffc;
			send_jobs(60, 1'b1, 2);
		end
		drain_records();
		if (rec_q.size() != 0 || bus_q.size() != 0)
			report_problem("Jobs left in the model after the final drain");
		close_test("random valid and pop", start);

		$display("Summary: %0d tests run, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, errors, dut.chk.fail_count);
		if (errors == 0 && dut.chk.fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
